// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [6:0] {
        R_TYPE     = 7'b0110011,
        R_TYPE_IMM = 7'b0010011,
        B_TYPE     = 7'b1100011,
        J_TYPE     = 7'b1101111,
        JALR_TYPE  = 7'b1100111,
        LUI_TYPE   = 7'b0110111,
        AUIPC_TYPE = 7'b0010111
    } opcode_e;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, COPY_B
    } alu_op_e;

    typedef enum logic [1:0] {RS1, PC, ZERO} a_sel_e;

    typedef enum logic [1:0] {NONE, FROM_MEM, FROM_WB} fwd_e;

    typedef enum logic {ALU, PC_PLUS_4} wb_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic            valid;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        a_sel_e          a_sel;
        logic            b_is_imm;
        logic            is_branch;
        logic            is_jump;
        wb_sel_e         wb_sel;
        logic            reg_wen;
        logic            valid;
    } id_ex_t;

    // also used for the MEM/WB slot
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        wb_sel_e               wb_sel;
        logic                  reg_wen;
        logic                  valid;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    input  logic                    i_redirect,
    input  logic [rv_pkg::XLEN-1:0] i_target,
    input  logic                    i_flush,
    output logic [rv_pkg::XLEN-1:0] o_pc,
    output rv_pkg::if_id_t          o_if_id
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    // a resolved branch or jump wins over sequential fetch
    assign pc_next = i_redirect ? i_target : pc + XLEN'(4);
    assign o_pc    = pc;

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            o_if_id <= '0;
        end else if (i_flush) begin
            // word fetched on the wrong path
            o_if_id <= '0;
        end else begin
            o_if_id <= '{pc: pc, inst: i_inst, valid: 1'b1};
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        pc[1:0] == 2'b00);

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  rv_pkg::if_id_t                i_if_id,
    input  logic                          i_flush,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    output rv_pkg::id_ex_t                o_id_ex
);
    import rv_pkg::*;

    logic [XLEN-1:0] inst;
    logic [2:0]      funct3;
    logic            funct7_alt;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    id_ex_t          dec;

    // funct3 to ALU op, alt selects SUB or SRA
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign inst       = i_if_id.inst;
    assign funct3     = inst[14:12];
    assign funct7_alt = inst[30];
    assign o_rs1_addr = inst[19:15];
    assign o_rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec          = '0;
        dec.pc       = i_if_id.pc;
        dec.inst     = inst;
        dec.rs1_data = i_rs1_data;
        dec.rs2_data = i_rs2_data;
        dec.alu_op   = ADD;
        dec.a_sel    = RS1;
        dec.wb_sel   = ALU;
        dec.valid    = i_if_id.valid;
        case (opcode_e'(inst[6:0]))
            R_TYPE: begin
                dec.alu_op  = alu_from_f3(funct3, funct7_alt);
                dec.reg_wen = 1'b1;
            end
            R_TYPE_IMM: begin
                // only the shift-right immediate uses funct7
                dec.alu_op   = alu_from_f3(funct3, funct7_alt && funct3 == 3'b101);
                dec.imm      = imm_i;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
            end
            B_TYPE: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            J_TYPE: begin
                dec.imm     = imm_j;
                dec.is_jump = 1'b1;
                dec.wb_sel  = PC_PLUS_4;
                dec.reg_wen = 1'b1;
            end
            JALR_TYPE: begin
                dec.imm     = imm_i;
                dec.is_jump = 1'b1;
                dec.wb_sel  = PC_PLUS_4;
                dec.reg_wen = 1'b1;
            end
            LUI_TYPE: begin
                dec.alu_op   = COPY_B;
                dec.a_sel    = ZERO;
                dec.imm      = imm_u;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
            end
            AUIPC_TYPE: begin
                dec.a_sel    = PC;
                dec.imm      = imm_u;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
            end
            default: begin
                // unknown opcode, send a bubble
                dec.valid = 1'b0;
            end
        endcase
        // x0 is never a write target
        dec.reg_wen = dec.reg_wen && inst[11:7] != '0;
    end

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            o_id_ex <= '0;
        end else if (i_flush) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex <= dec;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_rd_data,
    input  logic                          i_rd_wen,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:(1 << REG_ADDR_W) - 1];

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            for (int i = 1; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // same-cycle write is visible to the read ports
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                        (i_rd_wen && i_rd_addr == i_rs1_addr) ? i_rd_data : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                        (i_rd_wen && i_rd_addr == i_rs2_addr) ? i_rd_data : regs[i_rs2_addr];

    // a register read in the cycle after its write returns the stored data
    a_read_back: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rd_wen && i_rd_addr != '0) ##1
        (i_rs1_addr == $past(i_rd_addr) && !(i_rd_wen && i_rd_addr == i_rs1_addr))
        |-> o_rs1_data == $past(i_rd_data));

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  rv_pkg::id_ex_t                i_id_ex,
    input  rv_pkg::fwd_e                  i_fwd_a,
    input  rv_pkg::fwd_e                  i_fwd_b,
    input  logic [rv_pkg::XLEN-1:0]       i_mem_result,
    input  logic [rv_pkg::XLEN-1:0]       i_wb_result,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    output logic                          o_redirect,
    output logic [rv_pkg::XLEN-1:0]       o_target,
    output rv_pkg::ex_mem_t               o_ex_mem
);
    import rv_pkg::*;

    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] jalr_sum;
    logic            taken;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_e sel, input logic [XLEN-1:0] id_val,
                                                input logic [XLEN-1:0] mem_val,
                                                input logic [XLEN-1:0] wb_val);
        case (sel)
            FROM_MEM: return mem_val;
            FROM_WB:  return wb_val;
            default:  return id_val;
        endcase
    endfunction

    assign o_rs1_addr = i_id_ex.inst[19:15];
    assign o_rs2_addr = i_id_ex.inst[24:20];

    // forward register values first, then pick operands
    assign rs1 = fwd_mux(i_fwd_a, i_id_ex.rs1_data, i_mem_result, i_wb_result);
    assign rs2 = fwd_mux(i_fwd_b, i_id_ex.rs2_data, i_mem_result, i_wb_result);

    always_comb begin
        case (i_id_ex.a_sel)
            PC:      op_a = i_id_ex.pc;
            ZERO:    op_a = '0;
            default: op_a = rs1;
        endcase
    end

    assign op_b = i_id_ex.b_is_imm ? i_id_ex.imm : rs2;

    always_comb begin
        case (i_id_ex.alu_op)
            SUB:     result = op_a - op_b;
            SLL:     result = op_a << op_b[4:0];
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, op_a < op_b};
            XOR:     result = op_a ^ op_b;
            SRL:     result = op_a >> op_b[4:0];
            SRA:     result = $signed(op_a) >>> op_b[4:0];
            OR:      result = op_a | op_b;
            AND:     result = op_a & op_b;
            COPY_B:  result = op_b;
            default: result = op_a + op_b;
        endcase
    end

    // branch compare on the forwarded register values
    always_comb begin
        case (branch_e'(i_id_ex.inst[14:12]))
            BEQ:     taken = rs1 == rs2;
            BNE:     taken = rs1 != rs2;
            BLT:     taken = $signed(rs1) < $signed(rs2);
            BGE:     taken = $signed(rs1) >= $signed(rs2);
            BLTU:    taken = rs1 < rs2;
            BGEU:    taken = rs1 >= rs2;
            default: taken = 1'b0;
        endcase
    end

    assign o_redirect = i_id_ex.valid && (i_id_ex.is_jump || (i_id_ex.is_branch && taken));

    assign jalr_sum = rs1 + i_id_ex.imm;
    assign o_target = (opcode_e'(i_id_ex.inst[6:0]) == JALR_TYPE) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                                 : i_id_ex.pc + i_id_ex.imm;

    assign o_ex_mem = '{pc:      i_id_ex.pc,
                        rd:      i_id_ex.inst[11:7],
                        result:  result,
                        wb_sel:  i_id_ex.wb_sel,
                        reg_wen: i_id_ex.reg_wen,
                        valid:   i_id_ex.valid};

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_ex_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_ex_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_mem_rd,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic                          i_mem_wen,
    input  logic                          i_wb_wen,
    input  logic                          i_redirect,
    output rv_pkg::fwd_e                  o_fwd_a,
    output rv_pkg::fwd_e                  o_fwd_b,
    output logic                          o_flush_id,
    output logic                          o_flush_ex
);
    import rv_pkg::*;

    // the younger producer in MEM wins over WB
    function automatic fwd_e pick(input logic [REG_ADDR_W-1:0] rs,
                                  input logic [REG_ADDR_W-1:0] mem_rd, input logic mem_wen,
                                  input logic [REG_ADDR_W-1:0] wb_rd, input logic wb_wen);
        if (rs == '0) begin
            return NONE;
        end
        if (mem_wen && mem_rd == rs) begin
            return FROM_MEM;
        end
        if (wb_wen && wb_rd == rs) begin
            return FROM_WB;
        end
        return NONE;
    endfunction

    assign o_fwd_a = pick(i_ex_rs1, i_mem_rd, i_mem_wen, i_wb_rd, i_wb_wen);
    assign o_fwd_b = pick(i_ex_rs2, i_mem_rd, i_mem_wen, i_wb_rd, i_wb_wen);

    // both younger slots are on the wrong path
    assign o_flush_id = i_redirect;
    assign o_flush_ex = i_redirect;

endmodule

// ==== hdl/retire_stage.sv ====
`timescale 1ns/10ps

module retire_stage (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  rv_pkg::ex_mem_t               i_ex_mem,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_mem_rd,
    output logic                          o_mem_wen,
    output logic [rv_pkg::XLEN-1:0]       o_mem_result,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic                          o_wb_wen,
    output logic [rv_pkg::XLEN-1:0]       o_wb_result,
    output rv_pkg::retire_t               o_retire
);
    import rv_pkg::*;

    ex_mem_t mem_q;
    ex_mem_t wb_q;

    // jumps write the link address instead of the ALU result
    function automatic logic [XLEN-1:0] wb_value(input ex_mem_t slot);
        return (slot.wb_sel == PC_PLUS_4) ? slot.pc + XLEN'(4) : slot.result;
    endfunction

    always_ff @(posedge i_clk, posedge i_reset) begin
        if (i_reset) begin
            mem_q    <= '0;
            wb_q     <= '0;
            o_retire <= '0;
        end else begin
            mem_q    <= i_ex_mem;
            wb_q     <= mem_q;
            // record what the register file takes at this edge
            o_retire <= '{valid: wb_q.valid,
                          pc:    wb_q.pc,
                          rd:    wb_q.rd,
                          wen:   o_wb_wen,
                          data:  o_wb_wen ? o_wb_result : '0};
        end
    end

    assign o_mem_rd     = mem_q.rd;
    assign o_mem_wen    = mem_q.valid && mem_q.reg_wen;
    assign o_mem_result = wb_value(mem_q);

    assign o_wb_rd      = wb_q.rd;
    assign o_wb_wen     = wb_q.valid && wb_q.reg_wen;
    assign o_wb_result  = wb_value(wb_q);

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [rv_pkg::XLEN-1:0] i_imem_data,
    output logic [rv_pkg::XLEN-1:0] o_imem_addr,
    output rv_pkg::retire_t         o_retire
);
    import rv_pkg::*;

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem_next;

    logic [REG_ADDR_W-1:0] id_rs1_addr;
    logic [REG_ADDR_W-1:0] id_rs2_addr;
    logic [XLEN-1:0]       id_rs1_data;
    logic [XLEN-1:0]       id_rs2_data;

    logic [REG_ADDR_W-1:0] ex_rs1_addr;
    logic [REG_ADDR_W-1:0] ex_rs2_addr;
    logic                  redirect;
    logic [XLEN-1:0]       target;

    logic                  flush_id;
    logic                  flush_ex;
    fwd_e                  fwd_a;
    fwd_e                  fwd_b;

    logic [REG_ADDR_W-1:0] mem_rd;
    logic                  mem_wen;
    logic [XLEN-1:0]       mem_result;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  wb_wen;
    logic [XLEN-1:0]       wb_result;

    fetch_stage u_fetch (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_inst     (i_imem_data),
        .i_redirect (redirect),
        .i_target   (target),
        .i_flush    (flush_id),
        .o_pc       (o_imem_addr),
        .o_if_id    (if_id)
    );

    decode_stage u_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_if_id    (if_id),
        .i_flush    (flush_ex),
        .i_rs1_data (id_rs1_data),
        .i_rs2_data (id_rs2_data),
        .o_rs1_addr (id_rs1_addr),
        .o_rs2_addr (id_rs2_addr),
        .o_id_ex    (id_ex)
    );

    // written from the WB slot, read by decode
    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1_addr (id_rs1_addr),
        .i_rs2_addr (id_rs2_addr),
        .i_rd_addr  (wb_rd),
        .i_rd_data  (wb_result),
        .i_rd_wen   (wb_wen),
        .o_rs1_data (id_rs1_data),
        .o_rs2_data (id_rs2_data)
    );

    execute_stage u_execute (
        .i_id_ex      (id_ex),
        .i_fwd_a      (fwd_a),
        .i_fwd_b      (fwd_b),
        .i_mem_result (mem_result),
        .i_wb_result  (wb_result),
        .o_rs1_addr   (ex_rs1_addr),
        .o_rs2_addr   (ex_rs2_addr),
        .o_redirect   (redirect),
        .o_target     (target),
        .o_ex_mem     (ex_mem_next)
    );

    hazard_unit u_hazard (
        .i_ex_rs1   (ex_rs1_addr),
        .i_ex_rs2   (ex_rs2_addr),
        .i_mem_rd   (mem_rd),
        .i_wb_rd    (wb_rd),
        .i_mem_wen  (mem_wen),
        .i_wb_wen   (wb_wen),
        .i_redirect (redirect),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b),
        .o_flush_id (flush_id),
        .o_flush_ex (flush_ex)
    );

    retire_stage u_retire (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_ex_mem     (ex_mem_next),
        .o_mem_rd     (mem_rd),
        .o_mem_wen    (mem_wen),
        .o_mem_result (mem_result),
        .o_wb_rd      (wb_rd),
        .o_wb_wen     (wb_wen),
        .o_wb_result  (wb_result),
        .o_retire     (o_retire)
    );

endmodule

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int    IMEM_WORDS     = 256;
    localparam int    TIMEOUT_CYCLES = 200;
    localparam string STIM_FILE      = "verif/rv_core_stim.txt";

    // one expected retire record
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } expect_t;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] imem_data;
    logic [XLEN-1:0] imem_addr;
    retire_t         retire;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    int unsigned     num_words;
    expect_t         expected[$];

    int              checks;
    int              value_errors;
    int              timeouts;
    int              file_errors;

    rv_core i_dut (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_imem_data (imem_data),
        .o_imem_addr (imem_addr),
        .o_retire    (retire)
    );

    // past the program the port returns an illegal opcode, decoded as a bubble
    assign imem_data = (imem_addr[XLEN-1:2] < num_words) ? imem[imem_addr[9:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic log_error(input string msg);
        value_errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // next line that starts with a hex value, comments and blank lines skipped
    function automatic bit next_data_line(input int fd, output string line);
        string           raw;
        logic [XLEN-1:0] probe;
        while ($fgets(raw, fd) != 0) begin
            if ($sscanf(raw, "%h", probe) == 1) begin
                line = raw;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic load_stimulus();
        int              fd;
        int              count;
        string           line;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] data;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            file_errors++;
            $display("could not open the stimulus file %s", STIM_FILE);
            return;
        end
        if (!next_data_line(fd, line) || $sscanf(line, "%d", count) != 1
            || count > IMEM_WORDS) begin
            file_errors++;
            $display("stimulus file has no valid program word count");
        end else begin
            for (int i = 0; i < count; i++) begin
                if (!next_data_line(fd, line) || $sscanf(line, "%h", imem[i]) != 1) begin
                    file_errors++;
                    $display("stimulus file ends inside the program, word %0d", i);
                    break;
                end
                num_words++;
            end
        end
        if (!next_data_line(fd, line) || $sscanf(line, "%d", count) != 1) begin
            file_errors++;
            $display("stimulus file has no record count after the program");
        end else begin
            for (int i = 0; i < count; i++) begin
                if (!next_data_line(fd, line) || $sscanf(line, "%h %h %h", pc, rd, data) != 3) begin
                    file_errors++;
                    $display("stimulus file ends inside the records, record %0d", i);
                    break;
                end
                expected.push_back('{pc: pc, rd: rd[REG_ADDR_W-1:0], data: data});
            end
        end
        $fclose(fd);
    endtask

    // sampled on the falling edge, away from the retire register update
    task automatic wait_retire(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            seen = retire.valid;
        end
    endtask

    task automatic check_record(input expect_t exp, input int idx);
        checks++;
        assert (retire.pc == exp.pc) else
            log_error($sformatf("record %0d pc %h, expected %h", idx, retire.pc, exp.pc));
        if (exp.rd == '0) begin
            // no register written, so no write enable and zero data
            assert (!retire.wen && retire.data == '0) else
                log_error($sformatf("record %0d pc %h wen %b data %h, expected no write",
                                    idx, retire.pc, retire.wen, retire.data));
        end else begin
            assert (retire.wen && retire.rd == exp.rd && retire.data == exp.data) else
                log_error($sformatf("record %0d pc %h wen %b x%0d=%h, expected x%0d=%h",
                                    idx, retire.pc, retire.wen, retire.rd, retire.data,
                                    exp.rd, exp.data));
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, value errors %0d, timeouts %0d, file errors %0d",
                 checks, value_errors, timeouts, file_errors);
        if (value_errors + timeouts + file_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        bit seen;
        reset        = 1'b1;
        num_words    = 0;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        file_errors  = 0;
        load_stimulus();
        @(posedge clk);
        @(negedge clk);
        assert (!retire.valid) else
            log_error("retire valid while in reset");
        @(posedge clk);
        reset <= 1'b0;
        if (file_errors == 0) begin
            for (int i = 0; i < expected.size(); i++) begin
                wait_retire(seen);
                if (!seen) begin
                    timeouts++;
                    $display("no retire record %0d within %0d cycles", i, TIMEOUT_CYCLES);
                    break;
                end
                check_record(expected[i], i);
            end
        end
        finish_run();
    end

endmodule

// ==== rv_core.f ====
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/hazard_unit.sv
hdl/retire_stage.sv
hdl/rv_core.sv
verif/tb_rv_core.sv

// ==== verif/rv_core_stim.txt ====
# program: decimal word count, then one hex instruction word per line from pc 0
# records: decimal count, then pc rd data of each retired instruction, rd 00 when nothing is written
45
00500093  # 00 addi x1, x0, 5
FFD00113  # 04 addi x2, x0, -3
002081B3  # 08 add  x3, x1, x2      distance 1 and 2
40118233  # 0c sub  x4, x3, x1      distance 3 on x1
001122B3  # 10 slt  x5, x2, x1
00113333  # 14 sltu x6, x2, x1
005093B3  # 18 sll  x7, x1, x5
40115413  # 1c srai x8, x2, 1
01C15493  # 20 srli x9, x2, 28
0014C533  # 24 xor  x10, x9, x1
001565B3  # 28 or   x11, x10, x1
0075F633  # 2c and  x12, x11, x7
123456B7  # 30 lui  x13, 0x12345
00001717  # 34 auipc x14, 0x1
00700013  # 38 addi x0, x0, 7
001007B3  # 3c add  x15, x0, x1
00108463  # 40 beq  x1, x1, +8      taken
00100F93  # 44 addi x31, x0, 1      wrong path
00208463  # 48 beq  x1, x2, +8      not taken
00209463  # 4c bne  x1, x2, +8      taken
00100F93  # 50 wrong path
00109463  # 54 bne  x1, x1, +8      not taken
00114463  # 58 blt  x2, x1, +8      taken
00100F93  # 5c wrong path
0020C463  # 60 blt  x1, x2, +8      not taken
0020D463  # 64 bge  x1, x2, +8      taken
00100F93  # 68 wrong path
00115463  # 6c bge  x2, x1, +8      not taken
0020E463  # 70 bltu x1, x2, +8      taken
00100F93  # 74 wrong path
00116463  # 78 bltu x2, x1, +8      not taken
00117463  # 7c bgeu x2, x1, +8      taken
00100F93  # 80 wrong path
0020F463  # 84 bgeu x1, x2, +8      not taken
00C0086F  # 88 jal  x16, +12
00100F93  # 8c wrong path
00100F93  # 90 wrong path
0AC00893  # 94 addi x17, x0, 0xac
00188967  # 98 jalr x18, 1(x17)     target 0xac
00100F93  # 9c wrong path
00100F93  # a0 wrong path
00100F93  # a4 wrong path
00100F93  # a8 wrong path
010909B3  # ac add  x19, x18, x16
0000006F  # b0 jal  x0, 0
34
00000000 01 00000005
00000004 02 FFFFFFFD
00000008 03 00000002
0000000C 04 FFFFFFFD
00000010 05 00000001
00000014 06 00000000
00000018 07 0000000A
0000001C 08 FFFFFFFE
00000020 09 0000000F
00000024 0A 0000000A
00000028 0B 0000000F
0000002C 0C 0000000A
00000030 0D 12345000
00000034 0E 00001034
00000038 00 00000000
0000003C 0F 00000005
00000040 00 00000000
00000048 00 00000000
0000004C 00 00000000
00000054 00 00000000
00000058 00 00000000
00000060 00 00000000
00000064 00 00000000
0000006C 00 00000000
00000070 00 00000000
00000078 00 00000000
0000007C 00 00000000
00000084 00 00000000
00000088 10 0000008C
00000094 11 000000AC
00000098 12 0000009C
000000AC 13 00000128
000000B0 00 00000000
000000B0 00 00000000
